// File: Bender.yml
package:
  name: viterbi_decoder

sources:
  - hw/viterbi_pkg.sv
  - hw/branch_metric_unit.sv
  - hw/acs_butterfly.sv
  - hw/path_metric_store.sv
  - hw/survivor_path_decoder.sv
  - hw/viterbi_decoder.sv
  - target: test
    files:
      - testbench/viterbi_checker.sv
      - testbench/viterbi_tb.sv

// File: hw/acs_butterfly.sv
`timescale 1ns/1ps

// One radix-2 butterfly of the four-state trellis.
// Old states 2j and 2j+1 feed new states j (top) and j+2 (bottom).
module acs_butterfly (
  input  logic [viterbi_pkg::pm_w-1:0] pm_even,
  input  logic [viterbi_pkg::pm_w-1:0] pm_odd,
  input  logic [viterbi_pkg::bm_w-1:0] bm_top_even,
  input  logic [viterbi_pkg::bm_w-1:0] bm_top_odd,
  input  logic [viterbi_pkg::bm_w-1:0] bm_bot_even,
  input  logic [viterbi_pkg::bm_w-1:0] bm_bot_odd,
  output logic [viterbi_pkg::pm_w-1:0] npm_top,
  output logic [viterbi_pkg::pm_w-1:0] npm_bot,
  output logic                         sel_top,
  output logic                         sel_bot
);

  import viterbi_pkg::*;

  logic [pm_w-1:0] cand_top_even;
  logic [pm_w-1:0] cand_top_odd;
  logic [pm_w-1:0] cand_bot_even;
  logic [pm_w-1:0] cand_bot_odd;

  // Add. The sums simply wrap, no normalization is needed.
  assign cand_top_even = pm_even + pm_w'(bm_top_even);
  assign cand_top_odd  = pm_odd + pm_w'(bm_top_odd);
  assign cand_bot_even = pm_even + pm_w'(bm_bot_even);
  assign cand_bot_odd  = pm_odd + pm_w'(bm_bot_odd);

  // Compare. The odd path has to be strictly better, ties stay even.
  assign sel_top = pm_less(cand_top_odd, cand_top_even);
  assign sel_bot = pm_less(cand_bot_odd, cand_bot_even);

  // Select.
  assign npm_top = sel_top ? cand_top_odd : cand_top_even;
  assign npm_bot = sel_bot ? cand_bot_odd : cand_bot_even;

endmodule

// File: hw/branch_metric_unit.sv
`timescale 1ns/1ps

module branch_metric_unit (
  input  logic [1:0]                   cx,
  output logic [viterbi_pkg::bm_w-1:0] bm_00,
  output logic [viterbi_pkg::bm_w-1:0] bm_01,
  output logic [viterbi_pkg::bm_w-1:0] bm_10,
  output logic [viterbi_pkg::bm_w-1:0] bm_11
);

  import viterbi_pkg::*;

  // Number of differing bits between the received symbol and a codeword.
  function automatic logic [bm_w-1:0] hamming(
    input logic [1:0] rx,
    input logic [1:0] code
  );
    logic [1:0] diff;
    diff = rx ^ code;
    return bm_w'(diff[1]) + bm_w'(diff[0]);
  endfunction

  // Names follow the codeword as {gen_a bit, gen_b bit}.
  assign bm_00 = hamming(cx, 2'b00);
  assign bm_01 = hamming(cx, 2'b01);
  assign bm_10 = hamming(cx, 2'b10);
  assign bm_11 = hamming(cx, 2'b11);

endmodule

// File: hw/path_metric_store.sv
`timescale 1ns/1ps

module path_metric_store (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [viterbi_pkg::pm_w-1:0] npm0,
  input  logic [viterbi_pkg::pm_w-1:0] npm1,
  input  logic [viterbi_pkg::pm_w-1:0] npm2,
  input  logic [viterbi_pkg::pm_w-1:0] npm3,
  output logic [viterbi_pkg::pm_w-1:0] pm0,
  output logic [viterbi_pkg::pm_w-1:0] pm1,
  output logic [viterbi_pkg::pm_w-1:0] pm2,
  output logic [viterbi_pkg::pm_w-1:0] pm3,
  output logic [1:0]                   best_state
);

  import viterbi_pkg::*;

  logic            lo_pick1;
  logic            hi_pick3;
  logic            pick_hi;
  logic [pm_w-1:0] lo_best;
  logic [pm_w-1:0] hi_best;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pm0 <= '0; // State 0 is the start state.
      pm1 <= pm_init_other;
      pm2 <= pm_init_other;
      pm3 <= pm_init_other;
    end else begin
      pm0 <= npm0;
      pm1 <= npm1;
      pm2 <= npm2;
      pm3 <= npm3;
    end
  end

  // First level of the search tree. The lower index keeps a tie.
  assign lo_pick1 = pm_less(pm1, pm0);
  assign lo_best  = lo_pick1 ? pm1 : pm0;
  assign hi_pick3 = pm_less(pm3, pm2);
  assign hi_best  = hi_pick3 ? pm3 : pm2;

  // Second level, again strictly smaller to move to the upper pair.
  assign pick_hi    = pm_less(hi_best, lo_best);
  assign best_state = pick_hi ? {1'b1, hi_pick3} : {1'b0, lo_pick1};

endmodule

// File: hw/survivor_path_decoder.sv
`timescale 1ns/1ps

// Register exchange survivor memory.
// Bit 0 of a history is the newest decision and bit tb_depth-1 the oldest.
module survivor_path_decoder (
  input  logic       clk,
  input  logic       reset,
  input  logic       sel0,
  input  logic       sel1,
  input  logic       sel2,
  input  logic       sel3,
  input  logic [1:0] best_state,
  output logic       d,
  output logic       d_valid
);

  import viterbi_pkg::*;

  logic [num_states-1:0] sel;
  logic [tb_depth-1:0]   surv      [num_states];
  logic [tb_depth-1:0]   surv_next [num_states];
  logic [cnt_w-1:0]      cnt;
  logic                  load_out;

  assign sel = {sel3, sel2, sel1, sel0};

  // New state n comes from old state {n[0], sel[n]}.
  // Its decision bit, the input bit that led here, is n[1].
  always_comb begin
    logic [1:0] pred;
    pred = '0;
    for (int n = 0; n < num_states; n++) begin
      pred         = {n[0], sel[n]};
      surv_next[n] = {surv[pred][tb_depth-2:0], n[1]};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int n = 0; n < num_states; n++) begin
        surv[n] <= '0;
      end
    end else begin
      for (int n = 0; n < num_states; n++) begin
        surv[n] <= surv_next[n];
      end
    end
  end

  // The oldest bit becomes trustworthy once tb_depth + 1 symbols are in.
  assign load_out = d_valid | (cnt == cnt_w'(tb_depth + 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt     <= '0;
      d_valid <= 1'b0;
    end else if (!d_valid) begin
      if (cnt == cnt_w'(tb_depth + 1)) begin
        d_valid <= 1'b1; // Stays set until the next reset.
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      d <= 1'b0;
    end else begin
      d <= load_out & surv[best_state][tb_depth-1]; // Held at 0 until valid.
    end
  end

endmodule

// File: hw/viterbi_decoder.sv
`timescale 1ns/1ps

module viterbi_decoder (
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] cx,
  output logic       d,
  output logic       d_valid
);

  import viterbi_pkg::*;

  logic [bm_w-1:0] bm_00;
  logic [bm_w-1:0] bm_01;
  logic [bm_w-1:0] bm_10;
  logic [bm_w-1:0] bm_11;
  logic [pm_w-1:0] pm0;
  logic [pm_w-1:0] pm1;
  logic [pm_w-1:0] pm2;
  logic [pm_w-1:0] pm3;
  logic [pm_w-1:0] npm0;
  logic [pm_w-1:0] npm1;
  logic [pm_w-1:0] npm2;
  logic [pm_w-1:0] npm3;
  logic            sel0;
  logic            sel1;
  logic            sel2;
  logic            sel3;
  logic [1:0]      best_state;

  branch_metric_unit u_bmu (
    .cx    (cx),
    .bm_00 (bm_00),
    .bm_01 (bm_01),
    .bm_10 (bm_10),
    .bm_11 (bm_11)
  );

  // Old states 0 and 1 into new states 0 and 2.
  acs_butterfly u_acs_0 (
    .pm_even     (pm0),
    .pm_odd      (pm1),
    .bm_top_even (bm_00),
    .bm_top_odd  (bm_11),
    .bm_bot_even (bm_11),
    .bm_bot_odd  (bm_00),
    .npm_top     (npm0),
    .npm_bot     (npm2),
    .sel_top     (sel0),
    .sel_bot     (sel2)
  );

  // Old states 2 and 3 into new states 1 and 3.
  acs_butterfly u_acs_1 (
    .pm_even     (pm2),
    .pm_odd      (pm3),
    .bm_top_even (bm_10),
    .bm_top_odd  (bm_01),
    .bm_bot_even (bm_01),
    .bm_bot_odd  (bm_10),
    .npm_top     (npm1),
    .npm_bot     (npm3),
    .sel_top     (sel1),
    .sel_bot     (sel3)
  );

  path_metric_store u_pms (
    .clk        (clk),
    .reset      (reset),
    .npm0       (npm0),
    .npm1       (npm1),
    .npm2       (npm2),
    .npm3       (npm3),
    .pm0        (pm0),
    .pm1        (pm1),
    .pm2        (pm2),
    .pm3        (pm3),
    .best_state (best_state)
  );

  survivor_path_decoder u_spd (
    .clk        (clk),
    .reset      (reset),
    .sel0       (sel0),
    .sel1       (sel1),
    .sel2       (sel2),
    .sel3       (sel3),
    .best_state (best_state),
    .d          (d),
    .d_valid    (d_valid)
  );

endmodule

// File: hw/viterbi_pkg.sv
package viterbi_pkg;

  // Rate 1/2, constraint length 3 code with generators 7 and 5 (octal).
  // cx[1] carries the gen_a bit and cx[0] carries the gen_b bit.
  localparam logic [2:0] gen_a = 3'o7;
  localparam logic [2:0] gen_b = 3'o5;

  // A state holds the two previous input bits, the newest in the high bit.
  localparam int num_states = 4;

  // A hard decision branch metric is a Hamming distance of 0, 1 or 2.
  localparam int bm_w = 2;

  // Path metrics wrap around. The spread between live metrics stays well
  // below half the range, so a modulo compare orders them correctly.
  localparam int pm_w = 5;

  // Register exchange depth in symbols, which is also the decoder latency.
  localparam int tb_depth = 16;

  // Start metric of states 1 to 3. State 0 starts at zero, so the decoder
  // assumes the encoder begins in the all-zero state.
  localparam logic [pm_w-1:0] pm_init_other = 5'd4;

  // The valid counter has to reach tb_depth + 1.
  localparam int cnt_w = $clog2(tb_depth + 2);

  // Modulo compare of two path metrics.
  // True only when a is strictly smaller than b, so equal metrics return 0.
  function automatic logic pm_less(
    input logic [pm_w-1:0] a,
    input logic [pm_w-1:0] b
  );
    logic [pm_w-1:0] diff;
    diff = a - b; // Wraps modulo 2**pm_w.
    return diff[pm_w-1]; // A negative difference means a is behind b.
  endfunction

endpackage

// File: testbench/viterbi_checker.sv
`timescale 1ns/1ps

// Watches the decoder ports and runs an independent register-exchange model
// of the four-state trellis. Outputs are sampled at the rising edge, before
// the DUT registers take their new values.
module viterbi_checker (
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] cx,
  input  logic       d,
  input  logic       d_valid,
  input  logic       true_bit,
  input  logic       check_truth,
  input  logic [2:0] test_id,
  input  logic       end_test,
  input  logic       end_run,
  output int         error_count,
  output int         check_count
);

  import viterbi_pkg::*;

  localparam int ring = 1 << pm_w;

  int                  pm       [num_states];
  int                  pm_new   [num_states];
  logic [tb_depth-1:0] surv     [num_states];
  logic [tb_depth-1:0] surv_new [num_states];
  logic [tb_depth:0]   sent_hist; // Bit i is the input bit sent i + 1 edges ago.
  logic [tb_depth:0]   flag_hist;
  logic                exp_d;
  logic                exp_valid;
  logic                reset_seen = 1'b0;
  int                  edges;
  int                  test_checks = 0;
  int                  test_errors = 0;
  int                  total_checks = 0;
  int                  total_errors = 0;
  int                  tests_done = 0;

  assign error_count = total_errors;
  assign check_count = total_checks;

  // True when metric a lies in the half of the ring just below metric b.
  function automatic bit metric_smaller(input int a, input int b);
    int gap;
    gap = (a - b + 2 * ring) % ring;
    return gap >= ring / 2;
  endfunction

  // Hamming distance between the received symbol and the codeword of a branch.
  function automatic int branch_cost(input logic [1:0] rx, input int old_state, input logic u);
    logic [2:0] taps;
    logic [1:0] code;
    taps = {u, 2'(old_state)};
    code = {^(taps & gen_a), ^(taps & gen_b)};
    return int'(rx[1] ^ code[1]) + int'(rx[0] ^ code[0]);
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1: return "reset and valid timing";
      3'd2: return "clean channel";
      3'd3: return "isolated errors";
      3'd4: return "dense random errors";
      3'd5: return "metric wrap";
      3'd6: return "mid-run reset";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_bit(input string name, input logic expected, input logic actual);
    test_checks++;
    total_checks++;
    if (actual !== expected) begin
      test_errors++;
      total_errors++;
      $display("MISMATCH time=%0t signal=%s expected=%0b actual=%0b",
               $time, name, expected, actual);
    end
  endtask

  task automatic model_reset();
    for (int s = 0; s < num_states; s++) begin
      pm[s]   = (s == 0) ? 0 : int'(pm_init_other);
      surv[s] = '0;
    end
    sent_hist = '0;
    flag_hist = '0;
    exp_d     = 1'b0;
    exp_valid = 1'b0;
    edges     = 0;
  endtask

  task automatic model_step();
    int         best;
    int         even;
    int         odd;
    int         cand_even;
    int         cand_odd;
    logic [1:0] ns;
    if (edges < tb_depth + 2) begin
      edges++;
    end
    best = 0;
    for (int s = 1; s < num_states; s++) begin
      if (metric_smaller(pm[s], pm[best])) begin
        best = s; // Only a strictly smaller metric moves the choice upward.
      end
    end
    exp_valid = (edges >= tb_depth + 2);
    exp_d     = exp_valid ? surv[best][tb_depth-1] : 1'b0;
    for (int n = 0; n < num_states; n++) begin
      ns        = 2'(n);
      even      = 2 * int'(ns[0]);
      odd       = even + 1;
      cand_even = (pm[even] + branch_cost(cx, even, ns[1])) % ring;
      cand_odd  = (pm[odd] + branch_cost(cx, odd, ns[1])) % ring;
      if (metric_smaller(cand_odd, cand_even)) begin
        pm_new[n]   = cand_odd;
        surv_new[n] = {surv[odd][tb_depth-2:0], ns[1]};
      end else begin
        pm_new[n]   = cand_even;
        surv_new[n] = {surv[even][tb_depth-2:0], ns[1]};
      end
    end
    for (int n = 0; n < num_states; n++) begin
      pm[n]   = pm_new[n];
      surv[n] = surv_new[n];
    end
    sent_hist = {sent_hist[tb_depth-1:0], true_bit};
    flag_hist = {flag_hist[tb_depth-1:0], check_truth};
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (reset_seen) begin // The first edge can still see the power-up value.
        check_bit("d", 1'b0, d);
        check_bit("d_valid", 1'b0, d_valid);
      end
      model_reset();
      reset_seen = 1'b1;
    end else begin
      check_bit("d", exp_d, d);
      check_bit("d_valid", exp_valid, d_valid);
      if (exp_valid && flag_hist[tb_depth]) begin
        check_bit("d_vs_sent_bit", sent_hist[tb_depth], d); // Sent tb_depth symbols earlier.
      end
      model_step();
    end
    if (end_test) begin
      tests_done++;
      $display("test %0d (%s): %0d checks, %0d errors, %s", test_id, test_name(test_id),
               test_checks, test_errors, (test_errors == 0) ? "ok" : "failed");
      test_checks = 0;
      test_errors = 0;
    end
    if (end_run) begin
      $display("totals: %0d tests, %0d checks, %0d errors",
               tests_done, total_checks, total_errors);
    end
  end

endmodule

// File: testbench/viterbi_tb.sv
`timescale 1ns/1ps

module viterbi_tb;

  import viterbi_pkg::*;

  localparam int seed_value  = 73779;
  localparam int clean_len   = 400;
  localparam int sparse_len  = 400;
  localparam int sparse_gap  = 20;
  localparam int dense_len   = 600;
  localparam int wrap_len    = 1000; // Each half of the 2000 symbol run.
  localparam int burst_len   = 150;
  localparam int valid_limit = 3 * tb_depth;

  logic        clk;
  logic        reset;
  logic [1:0]  cx;
  logic        d;
  logic        d_valid;
  logic        true_bit;
  logic        check_truth;
  logic        end_test;
  logic        end_run;
  logic [2:0]  test_id;
  logic [1:0]  enc_state;
  logic [1:0]  flip;
  int          error_count;
  int          check_count;
  int unsigned seed;
  int unsigned dummy;

  viterbi_decoder u_dut (
    .clk     (clk),
    .reset   (reset),
    .cx      (cx),
    .d       (d),
    .d_valid (d_valid)
  );

  viterbi_checker u_chk (
    .clk         (clk),
    .reset       (reset),
    .cx          (cx),
    .d           (d),
    .d_valid     (d_valid),
    .true_bit    (true_bit),
    .check_truth (check_truth),
    .test_id     (test_id),
    .end_test    (end_test),
    .end_run     (end_run),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Encoder output for input u from state st, the gen_a bit first.
  function automatic logic [1:0] encode(input logic u, input logic [1:0] st);
    logic [2:0] taps;
    taps = {u, st};
    return {^(taps & gen_a), ^(taps & gen_b)};
  endfunction

  task automatic drive_symbol(input logic [1:0] flips, input logic flag);
    logic u;
    u           = 1'($urandom);
    cx          = encode(u, enc_state) ^ flips;
    true_bit    = u;
    check_truth = flag;
    end_test    = 1'b0;
    enc_state   = {u, enc_state[1]};
  endtask

  task automatic drive_raw(input logic [1:0] word);
    cx          = word;
    true_bit    = 1'b0;
    check_truth = 1'b0;
    end_test    = 1'b0;
  endtask

  // Each code bit flips with probability 1 in 8.
  task automatic draw_dense_flips();
    flip[1] = ($urandom % 8) == 0;
    flip[0] = ($urandom % 8) == 0;
  endtask

  task automatic send_clean(input int count, input logic flag);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      drive_symbol(2'b00, flag);
    end
  endtask

  task automatic close_test();
    @(negedge clk);
    drive_symbol(2'b00, 1'b0);
    end_test = 1'b1;
    @(negedge clk);
    drive_symbol(2'b00, 1'b0);
  endtask

  task automatic wait_for_valid(input logic flag);
    int waited;
    waited = 0;
    while (!d_valid && waited < valid_limit) begin
      @(negedge clk);
      drive_symbol(2'b00, flag);
      waited++;
    end
    if (!d_valid) begin
      $display("timeout: d_valid still low %0d cycles after reset release", valid_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  endtask

  task automatic pulse_reset(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      reset     = 1'b1;
      enc_state = 2'b00;
      drive_raw(2'($urandom)); // Traffic keeps arriving while the decoder is held.
    end
    @(negedge clk);
    reset = 1'b0;
    drive_symbol(2'b00, 1'b0);
  endtask

  initial begin
    reset       = 1'b1;
    cx          = 2'b00;
    true_bit    = 1'b0;
    check_truth = 1'b0;
    end_test    = 1'b0;
    end_run     = 1'b0;
    test_id     = 3'd1;
    enc_state   = 2'b00;
    flip        = 2'b00;
    seed        = seed_value;
    dummy       = $urandom(seed);

    repeat (10) @(negedge clk);
    reset = 1'b0;
    wait_for_valid(1'b1);
    close_test();

    test_id = 3'd2;
    send_clean(clean_len, 1'b1);
    send_clean(tb_depth + 2, 1'b0); // Lets the last checked bits reach d.
    close_test();

    test_id = 3'd3;
    for (int i = 0; i < sparse_len; i++) begin
      @(negedge clk);
      flip = 2'b00;
      if (i % sparse_gap == sparse_gap / 2) begin
        flip = ($urandom % 2 == 0) ? 2'b01 : 2'b10;
      end
      drive_symbol(flip, 1'b1);
    end
    send_clean(tb_depth + 2, 1'b0);
    close_test();

    test_id = 3'd4;
    for (int i = 0; i < dense_len; i++) begin
      @(negedge clk);
      draw_dense_flips();
      drive_symbol(flip, 1'b0);
    end
    close_test();

    test_id = 3'd5;
    for (int i = 0; i < wrap_len; i++) begin
      @(negedge clk);
      drive_raw(2'b11);
    end
    for (int i = 0; i < wrap_len; i++) begin
      @(negedge clk);
      drive_raw(2'($urandom));
    end
    close_test();

    test_id = 3'd6;
    for (int i = 0; i < burst_len; i++) begin
      @(negedge clk);
      draw_dense_flips();
      drive_symbol(flip, 1'b0);
    end
    pulse_reset(4);
    wait_for_valid(1'b0);
    for (int i = 0; i < burst_len; i++) begin
      @(negedge clk);
      draw_dense_flips();
      drive_symbol(flip, 1'b0);
    end
    close_test();

    @(negedge clk);
    drive_symbol(2'b00, 1'b0);
    end_run = 1'b1;
    @(negedge clk);
    end_run = 1'b0;
    if (error_count == 0 && check_count > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/viterbi_pkg.sv
hw/branch_metric_unit.sv
hw/acs_butterfly.sv
hw/path_metric_store.sv
hw/survivor_path_decoder.sv
hw/viterbi_decoder.sv
testbench/viterbi_checker.sv
testbench/viterbi_tb.sv
